// File: Makefile
# Verilator build and run for the execute stage testbench

SIM      := verilator
FLAGS    := --binary -j 0
TOP      := tb_exu
FILELIST := compile.f
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM), run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove build output and log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG); grep -q ">>> PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: compile.f
logic/exu_pkg.sv
logic/exu_bypass.sv
logic/exu_alu.sv
logic/exu_mul.sv
logic/exu_flush_ctl.sv
logic/exu.sv
sim/tb_exu.sv

// File: logic/exu.sv
// Execute stage top; no stall input, so the D to X to R pipe advances on every clock edge
`timescale 1ns/1ns

module exu (
   input  logic                          clk,
   input  logic                          i_rst_n,
   input  logic                          i_alu_valid_d,
   input  logic [exu_pkg::ALU_OP_W-1:0]  i_alu_op_d,
   input  logic                          i_branch_d,
   input  logic [exu_pkg::BR_OP_W-1:0]   i_br_op_d,
   input  logic                          i_pred_taken_d,
   input  logic [12:1]                   i_br_immed_d,
   input  logic                          i_mul_valid_d,
   input  logic [exu_pkg::MUL_OP_W-1:0]  i_mul_op_d,
   input  logic                          i_rs1_en_d,
   input  logic                          i_rs2_en_d,
   input  logic                          i_select_pc_d,
   input  logic [exu_pkg::XLEN-1:0]      i_gpr_rs1_d,
   input  logic [exu_pkg::XLEN-1:0]      i_gpr_rs2_d,
   input  logic [exu_pkg::XLEN-1:0]      i_immed_d,
   input  logic [exu_pkg::PC_W:1]        i_pc_d,
   input  logic [exu_pkg::BYP_W-1:0]     i_rs1_byp_d,
   input  logic [exu_pkg::BYP_W-1:0]     i_rs2_byp_d,
   input  logic [exu_pkg::XLEN-1:0]      i_result_r,
   input  logic                          i_flush_lower_r,
   input  logic [exu_pkg::PC_W:1]        i_flush_path_r,
   output logic [exu_pkg::XLEN-1:0]      o_result_x,
   output logic                          o_valid_x,
   output logic                          o_flush_final,
   output logic [exu_pkg::PC_W:1]        o_flush_path_final,
   output logic [exu_pkg::PC_W:1]        o_npc_r
);

   logic [exu_pkg::XLEN-1:0]  a_d;
   logic [exu_pkg::XLEN-1:0]  b_d;
   logic                      alu_valid_x;
   logic [exu_pkg::XLEN-1:0]  alu_result_x;
   logic                      mul_valid_x;
   logic [exu_pkg::XLEN-1:0]  mul_result_x;
   logic                      mispredict_x;
   logic                      pred_correct_x;
   logic [exu_pkg::PC_W:1]    flush_path_x;
   logic [exu_pkg::PC_W:1]    npc_x;

   exu_bypass u_bypass (
      .i_rs1_en_d     (i_rs1_en_d),     .i_rs2_en_d     (i_rs2_en_d),
      .i_select_pc_d  (i_select_pc_d),  .i_gpr_rs1_d    (i_gpr_rs1_d),
      .i_gpr_rs2_d    (i_gpr_rs2_d),    .i_immed_d      (i_immed_d),
      .i_pc_d         (i_pc_d),         .i_rs1_byp_d    (i_rs1_byp_d),
      .i_rs2_byp_d    (i_rs2_byp_d),    .i_result_r     (i_result_r),
      .i_alu_valid_x  (alu_valid_x),    .i_mul_valid_x  (mul_valid_x),
      .i_alu_result_x (alu_result_x),   .i_mul_result_x (mul_result_x),
      .o_a_d          (a_d),            .o_b_d          (b_d),
      .o_result_x     (o_result_x),     .o_valid_x      (o_valid_x)
   );

   exu_alu u_alu (
      .clk (clk), .i_rst_n (i_rst_n), .i_valid_d (i_alu_valid_d), .i_branch_d (i_branch_d),
      .i_pred_taken_d (i_pred_taken_d), .i_op_d (i_alu_op_d), .i_br_op_d (i_br_op_d),
      .i_a_d (a_d), .i_b_d (b_d), .i_pc_d (i_pc_d), .i_br_immed_d (i_br_immed_d),
      .i_flush_final (o_flush_final), .o_valid_x (alu_valid_x), .o_result_x (alu_result_x),
      .o_mispredict_x (mispredict_x), .o_pred_correct_x (pred_correct_x),
      .o_flush_path_x (flush_path_x), .o_npc_x (npc_x)
   );

   exu_mul u_mul (
      .clk (clk), .i_rst_n (i_rst_n), .i_valid_d (i_mul_valid_d),
      .i_flush_final (o_flush_final), .i_op_d (i_mul_op_d), .i_a_d (a_d), .i_b_d (b_d),
      .o_valid_x (mul_valid_x), .o_result_x (mul_result_x)
   );

   exu_flush_ctl u_flush (
      .clk (clk), .i_rst_n (i_rst_n), .i_mispredict_x (mispredict_x),
      .i_pred_correct_x (pred_correct_x), .i_flush_path_x (flush_path_x), .i_npc_x (npc_x),
      .i_flush_lower_r (i_flush_lower_r), .i_flush_path_r (i_flush_path_r),
      .o_flush_final (o_flush_final), .o_flush_path_final (o_flush_path_final),
      .o_npc_r (o_npc_r)
   );

endmodule

// File: logic/exu_alu.sv
// X-stage ALU and branch resolver; branch and JAL targets use only the 13-bit branch offset
`timescale 1ns/1ns

module exu_alu (
   input  logic                          clk,
   input  logic                          i_rst_n,
   input  logic                          i_valid_d,
   input  logic                          i_branch_d,
   input  logic                          i_pred_taken_d,
   input  logic [exu_pkg::ALU_OP_W-1:0]  i_op_d,
   input  logic [exu_pkg::BR_OP_W-1:0]   i_br_op_d,
   input  logic [exu_pkg::XLEN-1:0]      i_a_d,
   input  logic [exu_pkg::XLEN-1:0]      i_b_d,
   input  logic [exu_pkg::PC_W:1]        i_pc_d,
   input  logic [12:1]                   i_br_immed_d,
   input  logic                          i_flush_final,
   output logic                          o_valid_x,
   output logic [exu_pkg::XLEN-1:0]      o_result_x,
   output logic                          o_mispredict_x,
   output logic                          o_pred_correct_x,
   output logic [exu_pkg::PC_W:1]        o_flush_path_x,
   output logic [exu_pkg::PC_W:1]        o_npc_x
);

   logic                          load_d;
   logic                          valid_x;
   logic                          branch_x;
   logic                          pred_taken_x;
   logic [exu_pkg::ALU_OP_W-1:0]  op_x;
   logic [exu_pkg::BR_OP_W-1:0]   br_op_x;
   logic [exu_pkg::XLEN-1:0]      a_x;
   logic [exu_pkg::XLEN-1:0]      b_x;
   logic [exu_pkg::PC_W:1]        pc_x;
   logic [12:1]                   br_immed_x;
   logic [exu_pkg::PC_W:1]        npc_x;
   logic [exu_pkg::PC_W:1]        target_x;
   logic                          eq_x;
   logic                          lt_x;
   logic                          ltu_x;
   logic                          cond_x;
   logic                          is_jal_x;
   logic                          taken_x;
   logic                          ctl_x;
   logic [exu_pkg::XLEN-1:0]      result_x;

   assign load_d = i_valid_d & ~i_flush_final;  // Flushed D instruction never reaches X

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         valid_x      <= 1'b0;
         branch_x     <= 1'b0;
         pred_taken_x <= 1'b0;
         op_x         <= exu_pkg::ALU_ADD;
         br_op_x      <= exu_pkg::BR_EQ;
      end else begin
         valid_x <= load_d;
         if (load_d) begin
            branch_x     <= i_branch_d;
            pred_taken_x <= i_pred_taken_d;
            op_x         <= i_op_d;
            br_op_x      <= i_br_op_d;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (load_d) begin
         a_x        <= i_a_d;
         b_x        <= i_b_d;
         pc_x       <= i_pc_d;
         br_immed_x <= i_br_immed_d;
      end
   end

   assign npc_x    = pc_x + exu_pkg::PC_STEP;
   assign target_x = pc_x + {{(exu_pkg::PC_W-12){br_immed_x[12]}}, br_immed_x};

   assign eq_x  = (a_x == b_x);
   assign lt_x  = ($signed(a_x) < $signed(b_x));
   assign ltu_x = (a_x < b_x);

   always_comb begin
      case (br_op_x)
         exu_pkg::BR_EQ:  cond_x = eq_x;
         exu_pkg::BR_NE:  cond_x = ~eq_x;
         exu_pkg::BR_LT:  cond_x = lt_x;
         exu_pkg::BR_GE:  cond_x = ~lt_x;
         exu_pkg::BR_LTU: cond_x = ltu_x;
         exu_pkg::BR_GEU: cond_x = ~ltu_x;
         default:         cond_x = 1'b0;
      endcase
   end

   always_comb begin
      case (op_x)
         exu_pkg::ALU_ADD:  result_x = a_x + b_x;
         exu_pkg::ALU_SUB:  result_x = a_x - b_x;
         exu_pkg::ALU_AND:  result_x = a_x & b_x;
         exu_pkg::ALU_OR:   result_x = a_x | b_x;
         exu_pkg::ALU_XOR:  result_x = a_x ^ b_x;
         exu_pkg::ALU_SLL:  result_x = a_x << b_x[4:0];
         exu_pkg::ALU_SRL:  result_x = a_x >> b_x[4:0];
         exu_pkg::ALU_SRA:  result_x = $signed(a_x) >>> b_x[4:0];
         exu_pkg::ALU_SLT:  result_x = {{(exu_pkg::XLEN-1){1'b0}}, lt_x};
         exu_pkg::ALU_SLTU: result_x = {{(exu_pkg::XLEN-1){1'b0}}, ltu_x};
         exu_pkg::ALU_JAL:  result_x = {npc_x, 1'b0};             // Link address
         default:           result_x = '0;
      endcase
   end

   assign is_jal_x = (op_x == exu_pkg::ALU_JAL);
   assign taken_x  = is_jal_x | (branch_x & cond_x);           // Actual direction
   assign ctl_x    = valid_x & (branch_x | is_jal_x);          // Only control flow can mispredict

   assign o_valid_x        = valid_x;
   assign o_result_x       = result_x;
   assign o_mispredict_x   = ctl_x & (taken_x ^ pred_taken_x);
   assign o_pred_correct_x = ctl_x & ~(taken_x ^ pred_taken_x);
   assign o_flush_path_x   = taken_x ? target_x : npc_x;
   assign o_npc_x          = npc_x;

endmodule

// File: logic/exu_bypass.sv
// D-stage operand muxes fed by X and R forwarding; purely combinational, X bypass beats R bypass
`timescale 1ns/1ns

module exu_bypass (
   input  logic                        i_rs1_en_d,
   input  logic                        i_rs2_en_d,
   input  logic                        i_select_pc_d,
   input  logic [exu_pkg::XLEN-1:0]    i_gpr_rs1_d,
   input  logic [exu_pkg::XLEN-1:0]    i_gpr_rs2_d,
   input  logic [exu_pkg::XLEN-1:0]    i_immed_d,
   input  logic [exu_pkg::PC_W:1]      i_pc_d,
   input  logic [exu_pkg::BYP_W-1:0]   i_rs1_byp_d,
   input  logic [exu_pkg::BYP_W-1:0]   i_rs2_byp_d,
   input  logic [exu_pkg::XLEN-1:0]    i_result_r,
   input  logic                        i_alu_valid_x,
   input  logic                        i_mul_valid_x,
   input  logic [exu_pkg::XLEN-1:0]    i_alu_result_x,
   input  logic [exu_pkg::XLEN-1:0]    i_mul_result_x,
   output logic [exu_pkg::XLEN-1:0]    o_a_d,
   output logic [exu_pkg::XLEN-1:0]    o_b_d,
   output logic [exu_pkg::XLEN-1:0]    o_result_x,
   output logic                        o_valid_x
);

   logic [exu_pkg::XLEN-1:0] result_x;
   logic                     rs1_byp_en;
   logic                     rs2_byp_en;
   logic [exu_pkg::XLEN-1:0] rs1_byp_data;
   logic [exu_pkg::XLEN-1:0] rs2_byp_data;

   // Picks the forwarded value for one operand
   function automatic logic [exu_pkg::XLEN-1:0] byp_data(
      input logic [exu_pkg::BYP_W-1:0] sel,
      input logic [exu_pkg::XLEN-1:0]  res_x,
      input logic [exu_pkg::XLEN-1:0]  res_r
   );
      return sel[exu_pkg::BYP_X_BIT] ? res_x : res_r;
   endfunction

   assign result_x     = i_mul_valid_x ? i_mul_result_x : i_alu_result_x;  // Multiplier wins

   assign rs1_byp_en   = |i_rs1_byp_d;
   assign rs2_byp_en   = |i_rs2_byp_d;
   assign rs1_byp_data = byp_data(i_rs1_byp_d, result_x, i_result_r);
   assign rs2_byp_data = byp_data(i_rs2_byp_d, result_x, i_result_r);

   assign o_a_d = rs1_byp_en    ? rs1_byp_data :
                  i_select_pc_d ? {i_pc_d, 1'b0} :              // JAL and AUIPC style
                  i_rs1_en_d    ? i_gpr_rs1_d : '0;
   assign o_b_d = rs2_byp_en    ? rs2_byp_data :
                  i_rs2_en_d    ? i_gpr_rs2_d : i_immed_d;

   assign o_result_x = result_x;
   assign o_valid_x  = i_alu_valid_x | i_mul_valid_x;

endmodule

// File: logic/exu_flush_ctl.sv
// Final flush select and R-stage next PC; the external lower flush always outranks an X mispredict
`timescale 1ns/1ns

module exu_flush_ctl (
   input  logic                    clk,
   input  logic                    i_rst_n,
   input  logic                    i_mispredict_x,
   input  logic                    i_pred_correct_x,
   input  logic [exu_pkg::PC_W:1]  i_flush_path_x,
   input  logic [exu_pkg::PC_W:1]  i_npc_x,
   input  logic                    i_flush_lower_r,
   input  logic [exu_pkg::PC_W:1]  i_flush_path_r,
   output logic                    o_flush_final,
   output logic [exu_pkg::PC_W:1]  o_flush_path_final,
   output logic [exu_pkg::PC_W:1]  o_npc_r
);

   logic                    pred_correct_r;
   logic [exu_pkg::PC_W:1]  npc_r;
   logic [exu_pkg::PC_W:1]  flush_path_r;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pred_correct_r <= 1'b0;
         npc_r          <= '0;
         flush_path_r   <= '0;
      end else begin
         pred_correct_r <= i_pred_correct_x;
         npc_r          <= i_npc_x;
         flush_path_r   <= i_flush_path_x;     // Resolved target or fall-through
      end
   end

   assign o_flush_final      = i_flush_lower_r | i_mispredict_x;
   assign o_flush_path_final = i_flush_lower_r ? i_flush_path_r :   // Older instruction wins
                               i_mispredict_x  ? i_flush_path_x : '0;

   assign o_npc_r = pred_correct_r ? npc_r : flush_path_r;

endmodule

// File: logic/exu_mul.sv
// One-cycle 32x32 multiplier; MUL_LO ignores sign, MUL_HI is signed and MUL_HIU unsigned
`timescale 1ns/1ns

module exu_mul (
   input  logic                          clk,
   input  logic                          i_rst_n,
   input  logic                          i_valid_d,
   input  logic                          i_flush_final,
   input  logic [exu_pkg::MUL_OP_W-1:0]  i_op_d,
   input  logic [exu_pkg::XLEN-1:0]      i_a_d,
   input  logic [exu_pkg::XLEN-1:0]      i_b_d,
   output logic                          o_valid_x,
   output logic [exu_pkg::XLEN-1:0]      o_result_x
);

   logic                           valid_x;
   logic [exu_pkg::MUL_OP_W-1:0]   op_x;
   logic [exu_pkg::XLEN-1:0]       a_x;
   logic [exu_pkg::XLEN-1:0]       b_x;
   logic                           sgn_x;
   logic [2*exu_pkg::XLEN-1:0]     a_ext_x;
   logic [2*exu_pkg::XLEN-1:0]     b_ext_x;
   logic [2*exu_pkg::XLEN-1:0]     prod_x;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) valid_x <= 1'b0;
      else          valid_x <= i_valid_d & ~i_flush_final;
   end

   // Operands only move for a real multiply
   always_ff @(posedge clk) begin
      if (i_valid_d) begin
         op_x <= i_op_d;
         a_x  <= i_a_d;
         b_x  <= i_b_d;
      end
   end

   assign sgn_x   = (op_x == exu_pkg::MUL_HI);
   assign a_ext_x = {{exu_pkg::XLEN{sgn_x & a_x[exu_pkg::XLEN-1]}}, a_x};  // Sign or zero fill
   assign b_ext_x = {{exu_pkg::XLEN{sgn_x & b_x[exu_pkg::XLEN-1]}}, b_x};
   assign prod_x  = a_ext_x * b_ext_x;                    // Low 64 bits are exact

   assign o_valid_x  = valid_x;
   assign o_result_x = (op_x == exu_pkg::MUL_LO) ? prod_x[exu_pkg::XLEN-1:0] :
                                                   prod_x[2*exu_pkg::XLEN-1:exu_pkg::XLEN];

endmodule

// File: logic/exu_pkg.sv
// Shared widths and op codes for the execute stage; XLEN 32 only, PCs carry bits 31:1
package exu_pkg;

   localparam int unsigned XLEN        = 32;
   localparam int unsigned PC_W        = 31;      // PC bits 31:1
   localparam int unsigned INSTR_BYTES = 4;       // No compressed instructions
   localparam logic [PC_W-1:0] PC_STEP = PC_W'(INSTR_BYTES / 2);  // pc+4 in halfword units

   localparam int unsigned BYP_W     = 2;
   localparam int unsigned BYP_R_BIT = 0;         // R-stage result
   localparam int unsigned BYP_X_BIT = 1;         // X-stage result, wins over R

   localparam int unsigned ALU_OP_W = 4;
   localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
   localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
   localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd2;
   localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd3;
   localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd4;
   localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd5;
   localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd6;
   localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd7;
   localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd8;
   localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd9;
   localparam logic [ALU_OP_W-1:0] ALU_JAL  = 4'd10;  // Writes pc+4, always taken

   localparam int unsigned BR_OP_W = 3;
   localparam logic [BR_OP_W-1:0] BR_EQ  = 3'd0;
   localparam logic [BR_OP_W-1:0] BR_NE  = 3'd1;
   localparam logic [BR_OP_W-1:0] BR_LT  = 3'd2;
   localparam logic [BR_OP_W-1:0] BR_GE  = 3'd3;
   localparam logic [BR_OP_W-1:0] BR_LTU = 3'd4;
   localparam logic [BR_OP_W-1:0] BR_GEU = 3'd5;

   localparam int unsigned MUL_OP_W = 2;
   localparam logic [MUL_OP_W-1:0] MUL_LO  = 2'd0;   // Low word, sign does not matter
   localparam logic [MUL_OP_W-1:0] MUL_HI  = 2'd1;   // High word, signed x signed
   localparam logic [MUL_OP_W-1:0] MUL_HIU = 2'd2;   // High word, unsigned x unsigned

endpackage

// File: sim/exu_cases.txt
# b2b alu_v alu_op br br_op pred bimm mul_v mul_op rs1_en rs2_en sel_pc gpr1 gpr2 imm pc byp1 byp2
# res_r fl_lower fl_path, then expected result valid flush flush_path npc (x = no check); PCs in bytes
0 1 0 0 0 0 0 0 0 1 1 0 7fffffff 1 0 100 0 0 0 0 0 80000000 1 0 0 x
0 1 1 0 0 0 0 0 0 1 1 0 5 7 0 104 0 0 0 0 0 fffffffe 1 0 0 x
0 1 2 0 0 0 0 0 0 1 1 0 f0f0f0f0 ff00ff00 0 108 0 0 0 0 0 f000f000 1 0 0 x
0 1 3 0 0 0 0 0 0 1 1 0 f0f0f0f0 0f0f0000 0 10c 0 0 0 0 0 fffff0f0 1 0 0 x
0 1 4 0 0 0 0 0 0 1 1 0 aaaa5555 ffff0000 0 110 0 0 0 0 0 55555555 1 0 0 x
0 1 5 0 0 0 0 0 0 1 1 0 12345678 24 0 114 0 0 0 0 0 23456780 1 0 0 x
0 1 6 0 0 0 0 0 0 1 1 0 80000000 4 0 118 0 0 0 0 0 08000000 1 0 0 x
0 1 7 0 0 0 0 0 0 1 1 0 80000000 4 0 11c 0 0 0 0 0 f8000000 1 0 0 x
0 1 8 0 0 0 0 0 0 1 1 0 ffffffff 1 0 120 0 0 0 0 0 1 1 0 0 x
0 1 9 0 0 0 0 0 0 1 0 0 ffffffff 0 1 124 0 0 0 0 0 0 1 0 0 x
0 0 0 0 0 0 0 1 0 1 1 0 ffffffff ffffffff 0 128 0 0 0 0 0 1 1 0 0 x
0 0 0 0 0 0 0 1 1 1 1 0 80000000 80000000 0 12c 0 0 0 0 0 40000000 1 0 0 x
0 0 0 0 0 0 0 1 2 1 1 0 ffffffff ffffffff 0 130 0 0 0 0 0 fffffffe 1 0 0 x
0 0 0 0 0 0 0 1 1 1 1 0 fffffffe 3 0 134 0 0 0 0 0 ffffffff 1 0 0 x
0 1 0 0 0 0 0 0 0 1 1 0 10 20 0 138 0 0 0 0 0 30 1 0 0 x
1 1 0 0 0 0 0 0 0 1 1 0 dead 5 0 13c 2 0 0 0 0 35 1 0 0 x
1 1 1 0 0 0 0 0 0 1 1 0 100 bad 0 140 0 1 a 0 0 f6 1 0 0 x
1 1 3 0 0 0 0 0 0 1 1 0 0 1 0 144 3 0 ff00 0 0 f7 1 0 0 x
0 1 0 1 0 0 20 0 0 1 1 0 5 5 0 200 0 0 0 0 0 a 1 1 240 240
1 1 0 0 0 0 0 0 0 1 1 0 1 1 0 204 0 0 0 0 0 0 0 0 0 x
0 1 0 1 1 1 ff0 0 0 1 1 0 1 2 0 300 0 0 0 0 0 3 1 0 0 304
0 1 0 1 2 0 10 0 0 1 1 0 5 ffffffff 0 400 0 0 0 0 0 4 1 0 0 404
0 1 0 1 5 1 10 0 0 1 1 0 1 ffffffff 0 500 0 0 0 1 8000 0 1 1 8000 504
1 1 0 0 0 0 0 0 0 1 1 0 1 1 0 504 0 0 0 0 0 0 0 0 0 x
0 1 a 0 0 1 8 0 0 0 0 0 0 0 0 600 0 0 0 0 0 604 1 0 0 604

// File: sim/tb_exu.sv
// Reads sim/exu_cases.txt from the project root; up to 64 rows, PCs in the file are byte addresses
`timescale 1ns/1ns

module tb_exu;

   localparam int MAX_ROWS = 64;
   localparam int NCOL     = 26;

   logic clk = 1'b0;
   logic i_rst_n;
   logic i_alu_valid_d;
   logic i_branch_d;
   logic i_pred_taken_d;
   logic i_mul_valid_d;
   logic i_rs1_en_d;
   logic i_rs2_en_d;
   logic i_select_pc_d;
   logic i_flush_lower_r;
   logic [exu_pkg::ALU_OP_W-1:0] i_alu_op_d;
   logic [exu_pkg::BR_OP_W-1:0]  i_br_op_d;
   logic [exu_pkg::MUL_OP_W-1:0] i_mul_op_d;
   logic [12:1]                  i_br_immed_d;
   logic [exu_pkg::XLEN-1:0]     i_gpr_rs1_d;
   logic [exu_pkg::XLEN-1:0]     i_gpr_rs2_d;
   logic [exu_pkg::XLEN-1:0]     i_immed_d;
   logic [exu_pkg::XLEN-1:0]     i_result_r;
   logic [exu_pkg::PC_W:1]       i_pc_d;
   logic [exu_pkg::PC_W:1]       i_flush_path_r;
   logic [exu_pkg::BYP_W-1:0]    i_rs1_byp_d;
   logic [exu_pkg::BYP_W-1:0]    i_rs2_byp_d;
   logic [exu_pkg::XLEN-1:0]     o_result_x;
   logic                         o_valid_x;
   logic                         o_flush_final;
   logic [exu_pkg::PC_W:1]       o_flush_path_final;
   logic [exu_pkg::PC_W:1]       o_npc_r;

   logic [31:0] rows [MAX_ROWS][NCOL];
   bit          npc_chk [MAX_ROWS];
   int          nrows = 0;
   int          limit = 0;
   int          cycles = 0;
   int          d_row = -1;
   int          x_row = -1;
   int          r_row = -1;

   exu uut (.*);

   initial begin
      forever #20 clk = ~clk;   // 40 ns period
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (limit != 0 && cycles >= limit) begin
         $display("Timeout: the DUT did not finish the case rows within %0d cycles", limit);
         $display(">>> FAIL");
         $fatal(1, "timeout");
      end
   end

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp);
         $display(">>> FAIL");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic load_cases();
      int    fd;
      int    col;
      string tok;
      logic [31:0] v;
      fd  = $fopen("sim/exu_cases.txt", "r");
      col = 0;
      if (fd == 0) begin
         $display("Could not open the case file sim/exu_cases.txt");
         $display(">>> FAIL");
         $fatal(1, "no case file");
      end
      while (!$feof(fd) && nrows < MAX_ROWS) begin
         if ($fscanf(fd, "%s", tok) != 1) break;
         if (tok.getc(0) == "#") begin
            void'($fgets(tok, fd));   // Rest of a comment line
            continue;
         end
         if (col == NCOL-1 && tok == "x") begin
            npc_chk[nrows] = 1'b0;
            v = '0;
         end else begin
            void'($sscanf(tok, "%h", v));
            if (col == NCOL-1) npc_chk[nrows] = 1'b1;
         end
         rows[nrows][col] = v;
         col++;
         if (col == NCOL) begin
            col = 0;
            nrows++;
         end
      end
      $fclose(fd);
   endtask

   task automatic drive_row(input int r);
      logic [31:0] z [NCOL];
      for (int k = 0; k < NCOL; k++) z[k] = (r < 0) ? 32'h0 : rows[r][k];
      i_alu_valid_d  = z[1][0];
      i_alu_op_d     = z[2][3:0];
      i_branch_d     = z[3][0];
      i_br_op_d      = z[4][2:0];
      i_pred_taken_d = z[5][0];
      i_br_immed_d   = z[6][11:0];   // Offset bits 12:1
      i_mul_valid_d  = z[7][0];
      i_mul_op_d     = z[8][1:0];
      i_rs1_en_d     = z[9][0];
      i_rs2_en_d     = z[10][0];
      i_select_pc_d  = z[11][0];
      i_gpr_rs1_d    = z[12];
      i_gpr_rs2_d    = z[13];
      i_immed_d      = z[14];
      i_pc_d         = z[15][31:1];
      i_rs1_byp_d    = z[16][1:0];
      i_rs2_byp_d    = z[17][1:0];
      i_result_r     = z[18];
   endtask

   task automatic compare_outputs();
      if (x_row < 0) begin
         check_val("o_valid_x", 32'(o_valid_x), 32'h0);
         check_val("o_flush_final", 32'(o_flush_final), 32'h0);
      end else begin
         check_val("o_valid_x", 32'(o_valid_x), rows[x_row][22]);
         if (rows[x_row][22][0]) check_val("o_result_x", o_result_x, rows[x_row][21]);
         check_val("o_flush_final", 32'(o_flush_final), rows[x_row][23]);
         check_val("o_flush_path_final", {o_flush_path_final, 1'b0}, rows[x_row][24]);
      end
      if (r_row >= 0 && npc_chk[r_row]) check_val("o_npc_r", {o_npc_r, 1'b0}, rows[r_row][25]);
   endtask

   // Advances one clock and shifts the D, X and R slots before checking
   task automatic step(input int r);
      @(posedge clk);
      #2;
      r_row = x_row;
      x_row = d_row;
      d_row = r;
      drive_row(d_row);
      i_flush_lower_r = (x_row >= 0) ? rows[x_row][19][0] : 1'b0;
      i_flush_path_r  = (x_row >= 0) ? rows[x_row][20][31:1] : '0;
      @(negedge clk);
      compare_outputs();
   endtask

   initial begin
      int gap;
      void'($urandom(32'h8500));
      i_rst_n         = 1'b0;
      i_flush_lower_r = 1'b0;
      i_flush_path_r  = '0;
      drive_row(-1);
      load_cases();
      limit = nrows * 3 + 8 + 20;
      repeat (8) @(posedge clk);
      #2 i_rst_n = 1'b1;
      for (int r = 0; r < nrows; r++) begin
         gap = rows[r][0][0] ? 0 : int'($urandom % 3);   // Back-to-back rows stay together
         repeat (gap) step(-1);
         step(r);
      end
      step(-1);
      step(-1);   // Drain X and R
      $display(">>> PASS");
      $finish;
   end

endmodule
